// File: files.f
+incdir+verification
verilog/xoodyak_pkg.sv
verilog/xoodyak_ifs.sv
verilog/xoodoo_round.sv
verilog/xoodoo_permute.sv
verilog/cyclist_ctrl.sv
verilog/cyclist_state.sv
verilog/xoodyak_hash.sv
verification/xoodyak_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the Xoodyak hash engine and its testbench with Verilator, then run it.
# The run passes only if the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f files.f --top-module xoodyak_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vxoodyak_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi

echo "Pass line not found in $LOG"
exit 1

// File: verification/xoodyak_model.svh
//--------------------------------------------------------------------------
// Reference model of the Xoodoo permutation and the Cyclist hash duplex
// Included inside the testbench module, which imports xoodyak_pkg
// Lane (x,y) at word x+4y, bytes little endian within the state
// Hash mode only, with the engine's Down and Up modifier bytes
//--------------------------------------------------------------------------
`ifndef XOODYAK_MODEL_SVH
`define XOODYAK_MODEL_SVH

// Xoodoo round constants, one per round
function automatic logic [31:0] model_rc(input int r);
        case (r)
                0:       return 32'h058;
                1:       return 32'h038;
                2:       return 32'h3C0;
                3:       return 32'h0D0;
                4:       return 32'h120;
                5:       return 32'h014;
                6:       return 32'h060;
                7:       return 32'h02C;
                8:       return 32'h380;
                9:       return 32'h0F0;
                10:      return 32'h1A0;
                default: return 32'h012;
        endcase
endfunction

// Cyclic left shift, n from 1 to 31
function automatic logic [31:0] model_rotl(input logic [31:0] v, input int n);
        return (v << n) | (v >> (32 - n));
endfunction

// Full twelve-round Xoodoo on a 384-bit state
function automatic xoodoo_state_t model_xoodoo(input xoodoo_state_t s);
        logic [31:0] a [3][4];
        logic [31:0] b [3][4];
        logic [31:0] p [4];
        logic [31:0] e [4];
        for (int y = 0; y < 3; y++)
                for (int x = 0; x < 4; x++)
                        a[y][x] = s[32*(x+4*y) +: 32];
        for (int r = 0; r < 12; r++) begin
                // Theta, parity of the column to the west
                for (int x = 0; x < 4; x++)
                        p[x] = a[0][x] ^ a[1][x] ^ a[2][x];
                for (int x = 0; x < 4; x++)
                        e[x] = model_rotl(p[(x+3)%4], 5) ^ model_rotl(p[(x+3)%4], 14);
                // Rho-west and iota
                for (int x = 0; x < 4; x++) begin
                        b[0][x] = a[0][x] ^ e[x];
                        b[1][x] = a[1][(x+3)%4] ^ e[(x+3)%4];
                        b[2][x] = model_rotl(a[2][x] ^ e[x], 11);
                end
                b[0][0] = b[0][0] ^ model_rc(r);
                // Chi
                for (int y = 0; y < 3; y++)
                        for (int x = 0; x < 4; x++)
                                a[y][x] = b[y][x] ^ (~b[(y+1)%3][x] & b[(y+2)%3][x]);
                // Rho-east
                for (int x = 0; x < 4; x++) begin
                        b[0][x] = a[0][x];
                        b[1][x] = model_rotl(a[1][x], 1);
                        b[2][x] = model_rotl(a[2][(x+2)%4], 8);
                end
                a = b;
        end
        for (int y = 0; y < 3; y++)
                for (int x = 0; x < 4; x++)
                        s[32*(x+4*y) +: 32] = a[y][x];
        return s;
endfunction

// One command on the model, returns the cycles finished should stay low
function automatic int hash_model_cmd(inout xoodoo_state_t st, inout last_cmd_t last,
                inout hash_block_t text, input logic [3:0] code, input hash_block_t blk);
        int low;
        low = 0;
        case (code)
                CMD_INIT: begin
                        st   = '0;
                        last = LAST_INIT;
                        low  = 1;
                end
                CMD_ABSORB: begin
                        // Only a chained absorb permutes before its Down
                        low = 1;
                        if (last == LAST_ABSORB) begin
                                st  = model_xoodoo(st);
                                low = PERM_CYCLES + 1;
                        end
                        st[127:0]   = st[127:0] ^ blk;
                        st[135:128] = st[135:128] ^ PAD_BYTE;
                        st[383:376] = st[383:376] ^ CD_ABSORB;
                        last = LAST_ABSORB;
                end
                CMD_SQUEEZE: begin
                        if (last == LAST_SQUEEZE)
                                st[7:0] = st[7:0] ^ PAD_BYTE;
                        else
                                st[383:376] = st[383:376] ^ CU_SQUEEZE;
                        st   = model_xoodoo(st);
                        text = st[127:0];
                        last = LAST_SQUEEZE;
                        low  = PERM_CYCLES + 1;
                end
                default: low = 0;
        endcase
        return low;
endfunction

`endif

// File: verification/xoodyak_tb.sv
`timescale 1ns/1ps
`default_nettype none
//--------------------------------------------------------------------------
// Testbench for the Xoodyak hash engine
// Commands go in 1 ns after the rising edge and are held for one clock
// Each command is checked against the model for busy time and text_out
// Random data from a 32-bit Fibonacci LFSR with a fixed seed
//--------------------------------------------------------------------------
module xoodyak_tb
        import xoodyak_pkg::*;
();

        `include "xoodyak_model.svh"

        logic         eph1;
        logic         rst_n;
        logic [3:0]   op;
        hash_block_t  data_in;
        hash_block_t  text_out;
        logic         finished;

        // Model copy of the duplex
        xoodoo_state_t  m_state;
        last_cmd_t      m_last;
        hash_block_t    m_text;

        logic [31:0]  lfsr;
        int           errors;
        int           checks;
        int           tests_run;
        int           tests_failed;
        int           test_start_errors;
        logic         timed_out;
        int           max_busy = 50;

        xoodyak_hash uut (
                .eph1     (eph1),
                .rst_n    (rst_n),
                .op       (op),
                .data_in  (data_in),
                .text_out (text_out),
                .finished (finished)
        );

        initial begin
                eph1 = 1'b0;
                forever #5 eph1 = ~eph1;
        end

        // Taps 32, 22, 2, 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        task automatic take_bits(input int n, output logic [127:0] v);
                v = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr = lfsr_next(lfsr);
                        v    = {v[126:0], lfsr[0]};
                end
        endtask

        task automatic check_equal(input string what, input logic [127:0] got,
                        input logic [127:0] exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("ERR at %0t: %s, got %h expected %h", $time, what, got, exp);
                end
        endtask

        // Drive one command and count the clocks finished stays low
        task automatic issue(input logic [3:0] code, input hash_block_t blk);
                int low;
                int exp_low;
                if (timed_out)
                        return;
                exp_low = hash_model_cmd(m_state, m_last, m_text, code, blk);
                op      = code;
                data_in = blk;
                @(posedge eph1);
                #1;
                op      = '0;
                data_in = '0;
                low     = 0;
                while (!finished && low < max_busy) begin
                        @(posedge eph1);
                        #1;
                        low++;
                end
                if (!finished) begin
                        timed_out = 1'b1;
                        errors++;
                        $display("Timeout: finished still low %0d clocks after op %0d", low, code);
                end else begin
                        check_equal($sformatf("busy clocks for op %0d", code), 128'(low),
                                    128'(exp_low));
                        check_equal($sformatf("text_out after op %0d", code), text_out, m_text);
                end
        endtask

        task automatic start_test();
                test_start_errors = errors;
        endtask

        task automatic report_test(input string name);
                tests_run++;
                if (errors != test_start_errors) begin
                        tests_failed++;
                        $display("test %s: %0d errors", name, errors - test_start_errors);
                end else begin
                        $display("test %s: ok", name);
                end
        endtask

        initial begin
                hash_block_t   blk;
                hash_block_t   digest;
                logic [127:0]  r;
                int            n;

                rst_n     = 1'b0;
                op        = '0;
                data_in   = '0;
                lfsr      = 32'h154;
                errors    = 0;
                checks    = 0;
                tests_run = 0;
                tests_failed = 0;
                timed_out = 1'b0;
                m_state   = '0;
                m_last    = LAST_INIT;
                m_text    = '0;
                repeat (3) @(posedge eph1);
                #1;
                rst_n = 1'b1;

                // Idle and cleared out of reset
                start_test();
                check_equal("finished after reset", 128'(finished), 128'(1));
                check_equal("text_out after reset", text_out, '0);
                report_test("reset");

                start_test();
                take_bits(128, blk);
                issue(CMD_INIT, '0);
                issue(CMD_ABSORB, blk);
                issue(CMD_SQUEEZE, '0);
                report_test("single_absorb");

                // Three to five blocks with Up then Down on every later block
                start_test();
                issue(CMD_INIT, '0);
                take_bits(2, r);
                n = 3 + int'(r[1:0] % 2'd3);
                for (int i = 0; i < n; i++) begin
                        take_bits(128, blk);
                        issue(CMD_ABSORB, blk);
                end
                issue(CMD_SQUEEZE, '0);
                report_test("chained_absorb");

                start_test();
                issue(CMD_INIT, '0);
                take_bits(128, blk);
                issue(CMD_ABSORB, blk);
                repeat (4) issue(CMD_SQUEEZE, '0);
                report_test("extended_output");

                // Busy time per step kind and unknown codes that change nothing
                start_test();
                issue(CMD_INIT, '0);
                take_bits(128, blk);
                issue(CMD_ABSORB, blk);
                issue(CMD_ABSORB, ~blk);
                issue(CMD_SQUEEZE, '0);
                issue(CMD_ABSORB, blk);
                issue(4'd0, blk);
                issue(4'd2, blk);
                issue(4'd15, blk);
                issue(CMD_SQUEEZE, '0);
                issue(CMD_INIT, '0);
                report_test("command_timing");

                start_test();
                for (int i = 0; i < 200; i++) begin
                        take_bits(3, r);
                        case (r[2:0])
                                3'd0: issue(CMD_INIT, '0);
                                3'd1, 3'd2, 3'd3: begin
                                        take_bits(128, blk);
                                        issue(CMD_ABSORB, blk);
                                end
                                3'd4, 3'd5: issue(CMD_SQUEEZE, '0);
                                default: begin
                                        // Random 4-bit code that is mostly unknown
                                        take_bits(4, r);
                                        issue(r[3:0], '0);
                                end
                        endcase
                end
                // Same message after a re-init gives the same digest
                take_bits(128, blk);
                issue(CMD_INIT, '0);
                issue(CMD_ABSORB, blk);
                issue(CMD_ABSORB, ~blk);
                issue(CMD_SQUEEZE, '0);
                digest = m_text;
                issue(CMD_INIT, '0);
                issue(CMD_ABSORB, blk);
                issue(CMD_ABSORB, ~blk);
                issue(CMD_SQUEEZE, '0);
                check_equal("repeated digest", text_out, digest);
                report_test("random_stress");

                $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                         tests_run, tests_failed, checks, errors);
                if (errors == 0) begin
                        $display("ALL TESTS PASSED");
                end else begin
                        $display("SOME TESTS FAILED");
                end
                $finish;
        end

endmodule
`default_nettype wire

// File: verilog/cyclist_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
//--------------------------------------------------------------------------
// Command register for the Cyclist hash duplex
// op is sampled on every edge while finished is high
// Unknown codes are dropped, there is no other back-pressure
// step holds its value until the next accepted command
//--------------------------------------------------------------------------
module cyclist_ctrl
        import xoodyak_pkg::*;
(
        input  logic        eph1,
        input  logic        rst_n,
        input  logic [3:0]  op,
        output logic        finished,
        step_if.ctrl        step
);

        last_cmd_t      last_q;
        last_cmd_t      last_next;
        cyclist_step_t  step_next;
        logic           known;
        logic           accept;

        //------------------------------------------------------------------------
        // Step selection
        //------------------------------------------------------------------------
        always_comb begin
                known     = 1'b1;
                last_next = last_q;
                step_next = STEP_CLEAR;
                case (op)
                        CMD_INIT: begin
                                last_next = LAST_INIT;
                                step_next = STEP_CLEAR;
                        end
                        // A second absorb first has to bring the state up
                        CMD_ABSORB: begin
                                last_next = LAST_ABSORB;
                                if (last_q == LAST_ABSORB) begin
                                        step_next = STEP_UP_DOWN;
                                end else begin
                                        step_next = STEP_DOWN;
                                end
                        end
                        // Repeated squeezes give extended output
                        CMD_SQUEEZE: begin
                                last_next = LAST_SQUEEZE;
                                if (last_q == LAST_SQUEEZE) begin
                                        step_next = STEP_UP_MORE;
                                end else begin
                                        step_next = STEP_UP_FIRST;
                                end
                        end
                        default: begin
                                known = 1'b0;
                        end
                endcase
        end

        assign accept = finished & known;

        //------------------------------------------------------------------------
        // Idle flag, last command and step launch
        //------------------------------------------------------------------------
        always_ff @(posedge eph1 or negedge rst_n) begin
                if (!rst_n) begin
                        finished  <= 1'b1;
                        last_q    <= LAST_INIT;
                        step.go   <= 1'b0;
                        step.step <= STEP_CLEAR;
                end else begin
                        // go follows the accept edge by one clock
                        step.go <= accept;
                        if (accept) begin
                                finished  <= 1'b0;
                                last_q    <= last_next;
                                step.step <= step_next;
                        end else if (step.step_done) begin
                                finished <= 1'b1;
                        end
                end
        end

endmodule
`default_nettype wire

// File: verilog/cyclist_state.sv
`timescale 1ns/1ps
`default_nettype none
//--------------------------------------------------------------------------
// Cyclist state, Down and Up modifiers and squeeze output
// data_in is sampled with the command, while no step is running
// Up modifiers go in before the permutation, Down after it
// text_out only moves at the end of a squeeze
//--------------------------------------------------------------------------
module cyclist_state
        import xoodyak_pkg::*;
(
        input  logic         eph1,
        input  logic         rst_n,
        input  hash_block_t  data_in,
        output hash_block_t  text_out,
        step_if.dp           step,
        perm_if.user         perm
);

        xoodoo_state_t  state_q;
        hash_block_t    blk_q;
        xoodoo_state_t  down_mod;
        xoodoo_state_t  up_mod;
        logic           run_q;
        logic           is_up;
        logic           is_sqz;

        assign is_up  = step.step inside {STEP_UP_DOWN, STEP_UP_FIRST, STEP_UP_MORE};
        assign is_sqz = step.step inside {STEP_UP_FIRST, STEP_UP_MORE};

        //------------------------------------------------------------------------
        // Modifier words
        //------------------------------------------------------------------------
        // Down of X, block then pad byte, Cd in the last byte
        always_comb begin
                down_mod                        = '0;
                down_mod[8*BLOCK_BYTES-1:0]     = blk_q;
                down_mod[8*BLOCK_BYTES +: 8]    = PAD_BYTE;
                down_mod[8*DOMAIN_BYTE +: 8]    = CD_ABSORB;
        end

        // Cu for a first squeeze, empty-string Down for the next ones
        always_comb begin
                up_mod = '0;
                case (step.step)
                        STEP_UP_FIRST: up_mod[8*DOMAIN_BYTE +: 8] = CU_SQUEEZE;
                        STEP_UP_MORE:  up_mod[7:0]                = PAD_BYTE;
                        default:       up_mod                     = '0;
                endcase
        end

        assign perm.start    = step.go & is_up;
        assign perm.state_in = state_q ^ up_mod;

        // Short steps finish on the go clock, Up steps on done
        assign step.step_done = (step.go & ~is_up) | perm.done;

        // Block is held from the go clock until the permutation returns
        always_ff @(posedge eph1) begin
                if (!step.go && !run_q) begin
                        blk_q <= data_in;
                end
        end

        //------------------------------------------------------------------------
        // State and output registers
        //------------------------------------------------------------------------
        always_ff @(posedge eph1 or negedge rst_n) begin
                if (!rst_n) begin
                        state_q  <= '0;
                        text_out <= '0;
                        run_q    <= 1'b0;
                end else begin
                        if (perm.start) begin
                                run_q <= 1'b1;
                        end else if (perm.done) begin
                                run_q <= 1'b0;
                        end

                        if (perm.done) begin
                                // Chained absorb applies its Down on the new state
                                if (step.step == STEP_UP_DOWN) begin
                                        state_q <= perm.state_out ^ down_mod;
                                end else begin
                                        state_q <= perm.state_out;
                                end
                                if (is_sqz) begin
                                        text_out <= perm.state_out[8*BLOCK_BYTES-1:0];
                                end
                        end else if (step.go) begin
                                case (step.step)
                                        STEP_CLEAR: state_q <= '0;
                                        STEP_DOWN:  state_q <= state_q ^ down_mod;
                                        default:    state_q <= state_q;
                                endcase
                        end
                end
        end

endmodule
`default_nettype wire

// File: verilog/xoodoo_permute.sv
`timescale 1ns/1ps
`default_nettype none
//--------------------------------------------------------------------------
// Iterative Xoodoo permutation, three rounds per clock
// state_in is taken on the start clock, done follows PERM_CYCLES later
// state_out is only valid while done is high
//--------------------------------------------------------------------------
module xoodoo_permute
        import xoodyak_pkg::*;
(
        input  logic  eph1,
        input  logic  rst_n,
        perm_if.core  perm
);

        xoodoo_state_t  round_q;
        xoodoo_state_t  chain [ROUNDS_PER_CYCLE+1];
        logic [1:0]     cyc_q;
        logic           busy_q;
        logic           active;
        logic           last_cyc;

        assign active   = perm.start | busy_q;
        assign last_cyc = (cyc_q == 2'(PERM_CYCLES - 1));

        // First clock rounds the fresh input, later clocks the register
        assign chain[0] = busy_q ? round_q : perm.state_in;

        // Cycle k runs rounds 3k to 3k+2
        for (genvar i = 0; i < ROUNDS_PER_CYCLE; i++) begin : g_round
                xoodoo_round u_round (
                        .state_in  (chain[i]),
                        .rc        (ROUND_CONST[ROUNDS_PER_CYCLE * cyc_q + i]),
                        .state_out (chain[i+1])
                );
        end

        always_ff @(posedge eph1) begin
                if (active) begin
                        round_q <= chain[ROUNDS_PER_CYCLE];
                end
        end

        // Counter wraps back to zero after the last cycle
        always_ff @(posedge eph1 or negedge rst_n) begin
                if (!rst_n) begin
                        cyc_q     <= '0;
                        busy_q    <= 1'b0;
                        perm.done <= 1'b0;
                end else begin
                        perm.done <= active & last_cyc;
                        if (active) begin
                                cyc_q  <= cyc_q + 2'd1;
                                busy_q <= ~last_cyc;
                        end
                end
        end

        assign perm.state_out = round_q;

endmodule
`default_nettype wire

// File: verilog/xoodoo_round.sv
`timescale 1ns/1ps
`default_nettype none
//--------------------------------------------------------------------------
// One Xoodoo round, purely combinational
// Order is theta, rho-west, iota, chi, rho-east
// Planes are 128 bits, lane x at bits 32x+31:32x of its plane
//--------------------------------------------------------------------------
module xoodoo_round
        import xoodyak_pkg::*;
(
        input  xoodoo_state_t         state_in,
        input  logic [LANE_BITS-1:0]  rc,
        output xoodoo_state_t         state_out
);

        xoodoo_plane_t [2:0] a;
        xoodoo_plane_t [2:0] t;
        xoodoo_plane_t [2:0] w;
        xoodoo_plane_t [2:0] c;
        xoodoo_plane_t [2:0] r;
        xoodoo_plane_t       p;
        xoodoo_plane_t       e;

        // Cyclic shift towards higher z
        function automatic logic [LANE_BITS-1:0] rotl(
                input logic [LANE_BITS-1:0] v,
                input int                   n
        );
                return (v << n) | (v >> (LANE_BITS - n));
        endfunction

        assign a = state_in;

        always_comb begin
                // Theta
                // Column parity, taken from the west neighbour at z+5 and z+14
                p = a[0] ^ a[1] ^ a[2];
                for (int x = 0; x < 4; x++) begin
                        e[x] = rotl(p[(x + 3) % 4], 5) ^ rotl(p[(x + 3) % 4], 14);
                end
                for (int y = 0; y < 3; y++) begin
                        t[y] = a[y] ^ e;
                end

                // Rho-west
                // Plane 1 moves one lane east, plane 2 rotates by 11
                for (int x = 0; x < 4; x++) begin
                        w[0][x] = t[0][x];
                        w[1][x] = t[1][(x + 3) % 4];
                        w[2][x] = rotl(t[2][x], 11);
                end

                // Iota, constant lands in lane (0,0) at bit 0 up
                w[0][0] = w[0][0] ^ rc;

                // Chi, nonlinear mix across the three planes of a column
                for (int y = 0; y < 3; y++) begin
                        c[y] = w[y] ^ (~w[(y + 1) % 3] & w[(y + 2) % 3]);
                end

                // Rho-east
                // Plane 1 rotates by 1, plane 2 moves two lanes and rotates by 8
                for (int x = 0; x < 4; x++) begin
                        r[0][x] = c[0][x];
                        r[1][x] = rotl(c[1][x], 1);
                        r[2][x] = rotl(c[2][(x + 2) % 4], 8);
                end
        end

        assign state_out = r;

endmodule
`default_nettype wire

// File: verilog/xoodyak_hash.sv
`timescale 1ns/1ps
`default_nettype none
//--------------------------------------------------------------------------
// Xoodyak hash engine top level
// Commands 1 init, 3 absorb, 6 squeeze, one 16-byte block each
// Give a command only while finished is high, hold it for one clock
//--------------------------------------------------------------------------
module xoodyak_hash
        import xoodyak_pkg::*;
(
        input  logic         eph1,
        input  logic         rst_n,
        input  logic [3:0]   op,
        input  hash_block_t  data_in,
        output hash_block_t  text_out,
        output logic         finished
);

        perm_if perm_bus ();
        step_if step_bus ();

        // Command sampling and step choice
        cyclist_ctrl u_ctrl (
                .eph1     (eph1),
                .rst_n    (rst_n),
                .op       (op),
                .finished (finished),
                .step     (step_bus.ctrl)
        );

        // Duplex state and squeeze output
        cyclist_state u_state (
                .eph1     (eph1),
                .rst_n    (rst_n),
                .data_in  (data_in),
                .text_out (text_out),
                .step     (step_bus.dp),
                .perm     (perm_bus.user)
        );

        // Twelve-round permutation
        xoodoo_permute u_permute (
                .eph1     (eph1),
                .rst_n    (rst_n),
                .perm     (perm_bus.core)
        );

endmodule
`default_nettype wire

// File: verilog/xoodyak_ifs.sv
`timescale 1ns/1ps
`default_nettype none
//--------------------------------------------------------------------------
// Internal buses of the hash engine
// perm_if  start pulse with state_in, done pulse PERM_CYCLES clocks later
// step_if  go pulse with a held step code, step_done when it completes
// No start while a permutation is in flight
//--------------------------------------------------------------------------

// Datapath to permutation core
interface perm_if
        import xoodyak_pkg::*;
        ();

        logic           start;
        xoodoo_state_t  state_in;
        xoodoo_state_t  state_out;
        logic           done;

        // Cyclist datapath side
        modport user (
                output start,
                output state_in,
                input  state_out,
                input  done
        );

        // Permutation side
        modport core (
                input  start,
                input  state_in,
                output state_out,
                output done
        );

endinterface

// Controller to datapath
interface step_if
        import xoodyak_pkg::*;
        ();

        logic           go;
        cyclist_step_t  step;
        logic           step_done;

        modport ctrl (
                output go,
                output step,
                input  step_done
        );

        modport dp (
                input  go,
                input  step,
                output step_done
        );

endinterface
`default_nettype wire

// File: verilog/xoodyak_pkg.sv
`default_nettype none
//--------------------------------------------------------------------------
// Shared types and constants for the Xoodyak hash engine
// Byte i of the state sits at bits 8i+7:8i, lane (x,y) at word x+4y
// Hash mode only, one 16-byte block per absorb or squeeze command
// Round constants are applied at the low bits of lane (0,0)
//--------------------------------------------------------------------------
package xoodyak_pkg;

        //------------------------------------------------------------------------
        // Widths and permutation schedule
        //------------------------------------------------------------------------
        localparam int STATE_BITS  = 384;
        localparam int LANE_BITS   = 32;
        localparam int BLOCK_BYTES = 16;

        // Twelve rounds, three unrolled per clock
        localparam int N_ROUNDS         = 12;
        localparam int ROUNDS_PER_CYCLE = 3;
        localparam int PERM_CYCLES      = N_ROUNDS / ROUNDS_PER_CYCLE;

        // Round constants in round order
        localparam logic [LANE_BITS-1:0] ROUND_CONST [N_ROUNDS] = '{
                32'h058, 32'h038, 32'h3C0, 32'h0D0,
                32'h120, 32'h014, 32'h060, 32'h02C,
                32'h380, 32'h0F0, 32'h1A0, 32'h012
        };

        //------------------------------------------------------------------------
        // State and block types
        //------------------------------------------------------------------------
        typedef logic [STATE_BITS-1:0]     xoodoo_state_t;
        typedef logic [3:0][LANE_BITS-1:0] xoodoo_plane_t;
        typedef logic [8*BLOCK_BYTES-1:0]  hash_block_t;

        // Command codes on op
        localparam logic [3:0] CMD_INIT    = 4'd1;
        localparam logic [3:0] CMD_ABSORB  = 4'd3;
        localparam logic [3:0] CMD_SQUEEZE = 4'd6;

        // Padding and domain separation bytes
        localparam logic [7:0] PAD_BYTE    = 8'h01;
        localparam logic [7:0] CD_ABSORB   = 8'h03;
        localparam logic [7:0] CU_SQUEEZE  = 8'h40;
        localparam int         DOMAIN_BYTE = 47;

        // Duplex step handed from the controller to the datapath
        typedef enum logic [2:0] {
                STEP_CLEAR,
                STEP_DOWN,
                STEP_UP_DOWN,
                STEP_UP_FIRST,
                STEP_UP_MORE
        } cyclist_step_t;

        // Previous accepted command
        typedef enum logic [1:0] {
                LAST_INIT,
                LAST_ABSORB,
                LAST_SQUEEZE
        } last_cmd_t;

endpackage
`default_nettype wire
